/* design/idu_pkg.sv */
// Decode stage shared widths, opcode values, unit bus positions and instruction layouts
`default_nettype none

package idu_pkg;

   localparam int IW = 32;

   // Logic group opcodes
   localparam logic [5:0] OP_AND   = 6'h01;
   localparam logic [5:0] OP_AND_I = 6'h02;
   localparam logic [5:0] OP_OR    = 6'h03;
   localparam logic [5:0] OP_OR_I  = 6'h04;
   localparam logic [5:0] OP_XOR   = 6'h05;
   localparam logic [5:0] OP_XOR_I = 6'h06;
   localparam logic [5:0] OP_LSL   = 6'h07;
   localparam logic [5:0] OP_LSL_I = 6'h08;
   localparam logic [5:0] OP_LSR   = 6'h09;
   localparam logic [5:0] OP_LSR_I = 6'h0a;

   // Arithmetic group opcodes
   localparam logic [5:0] OP_CMP   = 6'h10;
   localparam logic [5:0] OP_ADD   = 6'h11;
   localparam logic [5:0] OP_ADD_I = 6'h12;
   localparam logic [5:0] OP_SUB   = 6'h13;
   localparam logic [5:0] OP_MUL   = 6'h14;
   localparam logic [5:0] OP_MHI   = 6'h15;

   // Memory group opcodes
   localparam logic [5:0] OP_LDB   = 6'h20;
   localparam logic [5:0] OP_LDH   = 6'h21;
   localparam logic [5:0] OP_LDW   = 6'h22;
   localparam logic [5:0] OP_STB   = 6'h24;
   localparam logic [5:0] OP_STH   = 6'h25;
   localparam logic [5:0] OP_STW   = 6'h26;
   localparam logic [5:0] OP_MBARR = 6'h28;

   // One-hot positions on the logic unit bus
   localparam int LU_W   = 5;
   localparam int LU_AND = 0;
   localparam int LU_OR  = 1;
   localparam int LU_XOR = 2;
   localparam int LU_LSL = 3;
   localparam int LU_LSR = 4;

   // One-hot positions on the arithmetic unit bus
   localparam int AU_W   = 5;
   localparam int AU_CMP = 0;
   localparam int AU_ADD = 1;
   localparam int AU_SUB = 2;
   localparam int AU_MUL = 3;
   localparam int AU_MHI = 4;

   // Memory access size codes
   localparam logic [2:0] SIZE_NONE = 3'd0;
   localparam logic [2:0] SIZE_B    = 3'd1;
   localparam logic [2:0] SIZE_H    = 3'd2;
   localparam logic [2:0] SIZE_W    = 3'd3;

   typedef struct packed {
      logic [7:0] attr;
      logic [5:0] rs2;
      logic [5:0] rs1;
      logic [5:0] rd;
      logic [5:0] opcode;
   } insn_reg_t;

   typedef struct packed {
      logic [13:0] imm14;
      logic [5:0]  rs1;
      logic [5:0]  rd;
      logic [5:0]  opcode;
   } insn_imm_t;

   typedef struct packed {
      logic [1:0]  pad;
      logic [17:0] imm18;
      logic [5:0]  rd;
      logic [5:0]  opcode;
   } insn_wide_t;

   // Same word seen as register, immediate or wide immediate form
   typedef union packed {
      insn_reg_t  r;
      insn_imm_t  i;
      insn_wide_t w;
   } insn_u;

endpackage

`default_nettype wire

/* design/idu_regf_rd_if.sv */
// Register file read bundle with two enabled read ports between decoder and register file
`timescale 1ns/1ps
`default_nettype none

interface idu_regf_rd_if #(
   parameter int DW     = 32,
   parameter int REG_AW = 5
) ();

   logic              rs1_re;
   logic [REG_AW-1:0] rs1_addr;
   logic [DW-1:0]     rs1_data;
   logic              rs2_re;
   logic [REG_AW-1:0] rs2_addr;
   logic [DW-1:0]     rs2_data;

   // Decoder side issues requests
   modport decoder (
      output rs1_re, rs1_addr, rs2_re, rs2_addr,
      input  rs1_data, rs2_data
   );

   modport regfile (
      input  rs1_re, rs1_addr, rs2_re, rs2_addr,
      output rs1_data, rs2_data
   );

endinterface

`default_nettype wire

/* design/idu_pipebuf.sv */
// One-entry valid/ready holding stage that issues the accept pulse for the decode registers
`timescale 1ns/1ps
`default_nettype none

module idu_pipebuf (
   input  wire  clk,
   input  wire  rst_i,
   input  wire  in_valid_i,
   output logic in_ready_o,
   output logic out_valid_o,
   input  wire  out_ready_i,
   output logic accept_o
);

   logic out_valid_r;

   // Free slot, or the held item leaves this cycle
   assign in_ready_o  = ~out_valid_r | out_ready_i;
   assign accept_o    = in_valid_i & in_ready_o;
   assign out_valid_o = out_valid_r;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         out_valid_r <= 1'b0;
      end else if (accept_o) begin
         out_valid_r <= 1'b1;
      end else if (out_ready_i) begin
         // Consumed with nothing new behind it
         out_valid_r <= 1'b0;
      end
   end

endmodule

`default_nettype wire

/* design/idu_regfile.sv */
// General purpose register file with two enabled registered read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module idu_regfile #(
   parameter int DW     = 32,
   parameter int REG_AW = 5
) (
   input  wire              clk,
   input  wire              rst_i,
   idu_regf_rd_if.regfile   rd,
   input  wire              wb_we_i,
   input  wire [REG_AW-1:0] wb_addr_i,
   input  wire [DW-1:0]     wb_data_i
);

   localparam int NREG = 2 ** REG_AW;

   logic [DW-1:0] regs [NREG];

   // Register 0 is never written, so it stays zero after reset
   always_ff @(posedge clk) begin
      if (rst_i) begin
         for (int i = 0; i < NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_we_i && (wb_addr_i != '0)) begin
         regs[wb_addr_i] <= wb_data_i;
      end
   end

   // Read data holds while the port is idle, keeping operands steady in a stall.
   // A same-edge write is not forwarded.
   always_ff @(posedge clk) begin
      if (rd.rs1_re) begin
         rd.rs1_data <= regs[rd.rs1_addr];
      end
      if (rd.rs2_re) begin
         rd.rs2_data <= regs[rd.rs2_addr];
      end
   end

endmodule

`default_nettype wire

/* design/idu_decoder.sv */
// Instruction decoder with opcode groups, immediates, register reads and the execute bundle
`timescale 1ns/1ps
`default_nettype none

module idu_decoder #(
   parameter int DW     = 32,
   parameter int REG_AW = 5
) (
   input  wire                        clk,
   input  wire                        rst_i,
   input  wire                        accept_i,
   input  idu_pkg::insn_u             insn_i,
   input  wire                        flush_i,
   idu_regf_rd_if.decoder             regf,
   output logic [DW-1:0]              operand1_o,
   output logic [DW-1:0]              operand2_o,
   output logic [DW-1:0]              operand3_o,
   output logic [idu_pkg::LU_W-1:0]   lu_opc_o,
   output logic [idu_pkg::AU_W-1:0]   au_opc_o,
   output logic [2:0]                 load_size_o,
   output logic [2:0]                 store_size_o,
   output logic                       load_o,
   output logic                       store_o,
   output logic                       barr_o,
   output logic                       emu_o,
   output logic                       wb_regf_o,
   output logic [REG_AW-1:0]          wb_reg_addr_o
);

   logic [5:0] opc;
   logic op_and_i, op_or_i, op_xor_i, op_lsl_i, op_lsr_i, op_add_i;
   logic op_cmp, op_mhi, op_ldb, op_ldh, op_ldw, op_stb, op_sth, op_stw, op_barr;
   logic [idu_pkg::LU_W-1:0] lu_opc;
   logic [idu_pkg::AU_W-1:0] au_opc;
   logic [2:0] load_size, store_size;
   logic op_load, op_store, emu, wb_regf;
   logic insn_imm14, imm14_signed, insn_imm, reg_form;
   logic [DW-1:0] simm14, uimm14, uimm18, imm_nxt, imm_r;
   logic rs1_frm_regf_r, rs2_frm_regf_r;

   assign opc = insn_i.r.opcode;

   assign op_and_i = (opc == idu_pkg::OP_AND_I);
   assign op_or_i  = (opc == idu_pkg::OP_OR_I);
   assign op_xor_i = (opc == idu_pkg::OP_XOR_I);
   assign op_lsl_i = (opc == idu_pkg::OP_LSL_I);
   assign op_lsr_i = (opc == idu_pkg::OP_LSR_I);
   assign op_add_i = (opc == idu_pkg::OP_ADD_I);
   assign op_cmp   = (opc == idu_pkg::OP_CMP);
   assign op_mhi   = (opc == idu_pkg::OP_MHI);
   assign op_ldb   = (opc == idu_pkg::OP_LDB);
   assign op_ldh   = (opc == idu_pkg::OP_LDH);
   assign op_ldw   = (opc == idu_pkg::OP_LDW);
   assign op_stb   = (opc == idu_pkg::OP_STB);
   assign op_sth   = (opc == idu_pkg::OP_STH);
   assign op_stw   = (opc == idu_pkg::OP_STW);
   assign op_barr  = (opc == idu_pkg::OP_MBARR);

   // Immediate and register forms share one unit bit
   assign lu_opc[idu_pkg::LU_AND] = (opc == idu_pkg::OP_AND) | op_and_i;
   assign lu_opc[idu_pkg::LU_OR]  = (opc == idu_pkg::OP_OR)  | op_or_i;
   assign lu_opc[idu_pkg::LU_XOR] = (opc == idu_pkg::OP_XOR) | op_xor_i;
   assign lu_opc[idu_pkg::LU_LSL] = (opc == idu_pkg::OP_LSL) | op_lsl_i;
   assign lu_opc[idu_pkg::LU_LSR] = (opc == idu_pkg::OP_LSR) | op_lsr_i;

   assign au_opc[idu_pkg::AU_CMP] = op_cmp;
   assign au_opc[idu_pkg::AU_ADD] = (opc == idu_pkg::OP_ADD) | op_add_i;
   assign au_opc[idu_pkg::AU_SUB] = (opc == idu_pkg::OP_SUB);
   assign au_opc[idu_pkg::AU_MUL] = (opc == idu_pkg::OP_MUL);
   assign au_opc[idu_pkg::AU_MHI] = op_mhi;

   assign load_size  = op_ldb ? idu_pkg::SIZE_B : op_ldh ? idu_pkg::SIZE_H :
                       op_ldw ? idu_pkg::SIZE_W : idu_pkg::SIZE_NONE;
   assign store_size = op_stb ? idu_pkg::SIZE_B : op_sth ? idu_pkg::SIZE_H :
                       op_stw ? idu_pkg::SIZE_W : idu_pkg::SIZE_NONE;
   assign op_load  = |load_size;
   assign op_store = |store_size;

   // Nothing recognised, hand it to software
   assign emu     = ~((|lu_opc) | (|au_opc) | op_load | op_store | op_barr);
   assign wb_regf = ~(op_cmp | op_store | op_barr | emu);

   assign insn_imm14   = op_and_i | op_or_i | op_xor_i | op_lsl_i | op_lsr_i | op_add_i |
                         op_load | op_store;
   assign imm14_signed = op_and_i | op_xor_i | op_add_i | op_load | op_store;
   assign insn_imm     = insn_imm14 | op_mhi;
   assign reg_form     = ~insn_imm & ~op_barr;

   assign simm14  = {{(DW-14){insn_i.i.imm14[13]}}, insn_i.i.imm14};
   assign uimm14  = {{(DW-14){1'b0}}, insn_i.i.imm14};
   assign uimm18  = {{(DW-18){1'b0}}, insn_i.w.imm18};
   assign imm_nxt = insn_imm14 ? (imm14_signed ? simm14 : uimm14) : uimm18;

   // Stores fetch the data register through the rs2 port
   assign regf.rs1_re   = accept_i & ~op_barr;
   assign regf.rs1_addr = insn_i.r.rs1[REG_AW-1:0];
   assign regf.rs2_re   = accept_i & (reg_form | op_store);
   assign regf.rs2_addr = op_store ? insn_i.r.rd[REG_AW-1:0] : insn_i.r.rs2[REG_AW-1:0];

   always_ff @(posedge clk) begin
      if (rst_i) begin
         lu_opc_o       <= '0;
         au_opc_o       <= '0;
         load_size_o    <= idu_pkg::SIZE_NONE;
         store_size_o   <= idu_pkg::SIZE_NONE;
         rs1_frm_regf_r <= 1'b0;
         rs2_frm_regf_r <= 1'b0;
         load_o         <= 1'b0;
         store_o        <= 1'b0;
         barr_o         <= 1'b0;
         emu_o          <= 1'b0;
         wb_regf_o      <= 1'b0;
      end else if (accept_i) begin
         lu_opc_o       <= lu_opc;
         au_opc_o       <= au_opc;
         load_size_o    <= load_size;
         store_size_o   <= store_size;
         rs1_frm_regf_r <= ~op_barr;
         rs2_frm_regf_r <= reg_form;
         // Flush kills the side effects only
         load_o         <= op_load & ~flush_i;
         store_o        <= op_store & ~flush_i;
         barr_o         <= op_barr & ~flush_i;
         emu_o          <= emu & ~flush_i;
         wb_regf_o      <= wb_regf & ~flush_i;
      end
   end

   always_ff @(posedge clk) begin
      if (accept_i) begin
         imm_r         <= imm_nxt;
         wb_reg_addr_o <= insn_i.r.rd[REG_AW-1:0];
      end
   end

   assign operand1_o = rs1_frm_regf_r ? regf.rs1_data : imm_r;
   assign operand2_o = rs2_frm_regf_r ? regf.rs2_data : imm_r;
   // Store size survives a flush, so operand3 stays intact
   assign operand3_o = (|store_size_o) ? regf.rs2_data : '0;

endmodule

`default_nettype wire

/* design/idu_top.sv */
// Decode stage top level joining the handshake buffer, decoder and register file
`timescale 1ns/1ps
`default_nettype none

module idu_top #(
   parameter int DW     = 32,
   parameter int REG_AW = 5
) (
   input  wire                        clk,
   input  wire                        rst_i,
   input  wire                        insn_valid_i,
   output logic                       insn_ready_o,
   input  wire [idu_pkg::IW-1:0]      insn_i,
   input  wire                        flush_i,
   output logic                       ex_valid_o,
   input  wire                        ex_ready_i,
   input  wire                        wb_we_i,
   input  wire [REG_AW-1:0]           wb_addr_i,
   input  wire [DW-1:0]               wb_data_i,
   output logic [DW-1:0]              operand1_o,
   output logic [DW-1:0]              operand2_o,
   output logic [DW-1:0]              operand3_o,
   output logic [idu_pkg::LU_W-1:0]   lu_opc_o,
   output logic [idu_pkg::AU_W-1:0]   au_opc_o,
   output logic [2:0]                 load_size_o,
   output logic [2:0]                 store_size_o,
   output logic                       load_o,
   output logic                       store_o,
   output logic                       barr_o,
   output logic                       emu_o,
   output logic                       wb_regf_o,
   output logic [REG_AW-1:0]          wb_reg_addr_o
);

   logic accept;

   idu_regf_rd_if #(.DW(DW), .REG_AW(REG_AW)) regf_rd ();

   idu_pipebuf u_pipebuf (
      .clk         (clk),
      .rst_i       (rst_i),
      .in_valid_i  (insn_valid_i),
      .in_ready_o  (insn_ready_o),
      .out_valid_o (ex_valid_o),
      .out_ready_i (ex_ready_i),
      .accept_o    (accept)
   );

   idu_decoder #(.DW(DW), .REG_AW(REG_AW)) u_decoder (
      .clk           (clk),
      .rst_i         (rst_i),
      .accept_i      (accept),
      .insn_i        (insn_i),
      .flush_i       (flush_i),
      .regf          (regf_rd.decoder),
      .operand1_o    (operand1_o),
      .operand2_o    (operand2_o),
      .operand3_o    (operand3_o),
      .lu_opc_o      (lu_opc_o),
      .au_opc_o      (au_opc_o),
      .load_size_o   (load_size_o),
      .store_size_o  (store_size_o),
      .load_o        (load_o),
      .store_o       (store_o),
      .barr_o        (barr_o),
      .emu_o         (emu_o),
      .wb_regf_o     (wb_regf_o),
      .wb_reg_addr_o (wb_reg_addr_o)
   );

   idu_regfile #(.DW(DW), .REG_AW(REG_AW)) u_regfile (
      .clk       (clk),
      .rst_i     (rst_i),
      .rd        (regf_rd.regfile),
      .wb_we_i   (wb_we_i),
      .wb_addr_i (wb_addr_i),
      .wb_data_i (wb_data_i)
   );

endmodule

`default_nettype wire

/* tb/tb_idu_table.svh */
// Decode stage stimulus table with one instruction word, flush bit and expected class per row
// Columns of add_row are the instruction word, the flush bit and the expected decode class

task automatic fill_stimulus_table();
   // Logic group, with register 0 and a wrapped 6-bit register field
   add_row(reg_form_word(idu_pkg::OP_AND, 6'd3, 6'd1, 6'd2), 1'b0, CLASS_LOGIC);
   add_row(imm_form_word(idu_pkg::OP_AND_I, 6'd4, 6'd5, 14'h3ffd), 1'b0, CLASS_LOGIC);
   add_row(reg_form_word(idu_pkg::OP_OR, 6'd6, 6'd7, 6'd0), 1'b0, CLASS_LOGIC);
   add_row(imm_form_word(idu_pkg::OP_OR_I, 6'd8, 6'd9, 14'h2abc), 1'b0, CLASS_LOGIC);
   add_row(reg_form_word(idu_pkg::OP_XOR, 6'd10, 6'd11, 6'd12), 1'b0, CLASS_LOGIC);
   add_row(imm_form_word(idu_pkg::OP_XOR_I, 6'd1, 6'd2, 14'h2001), 1'b0, CLASS_LOGIC);
   add_row(reg_form_word(idu_pkg::OP_LSL, 6'd2, 6'd0, 6'd3), 1'b0, CLASS_LOGIC);
   add_row(imm_form_word(idu_pkg::OP_LSL_I, 6'd3, 6'd4, 14'h001f), 1'b0, CLASS_LOGIC);
   add_row(reg_form_word(idu_pkg::OP_LSR, 6'd4, 6'd37, 6'd6), 1'b0, CLASS_LOGIC);
   add_row(imm_form_word(idu_pkg::OP_LSR_I, 6'd5, 6'd6, 14'h3fff), 1'b0, CLASS_LOGIC);

   // Arithmetic group
   add_row(reg_form_word(idu_pkg::OP_CMP, 6'd0, 6'd7, 6'd8), 1'b0, CLASS_ARITH);
   add_row(reg_form_word(idu_pkg::OP_ADD, 6'd9, 6'd10, 6'd11), 1'b0, CLASS_ARITH);
   add_row(imm_form_word(idu_pkg::OP_ADD_I, 6'd12, 6'd13, 14'h1234), 1'b0, CLASS_ARITH);
   add_row(reg_form_word(idu_pkg::OP_SUB, 6'd14, 6'd15, 6'd16), 1'b0, CLASS_ARITH);
   add_row(reg_form_word(idu_pkg::OP_MUL, 6'd17, 6'd51, 6'd18), 1'b0, CLASS_ARITH);
   add_row(wide_form_word(idu_pkg::OP_MHI, 6'd20, 18'h2abcd), 1'b0, CLASS_ARITH);

   // Loads and stores, negative and positive offsets
   add_row(imm_form_word(idu_pkg::OP_LDB, 6'd21, 6'd22, 14'h3ff0), 1'b0, CLASS_LOAD);
   add_row(imm_form_word(idu_pkg::OP_LDH, 6'd23, 6'd24, 14'h0040), 1'b0, CLASS_LOAD);
   add_row(imm_form_word(idu_pkg::OP_LDW, 6'd25, 6'd26, 14'h2000), 1'b0, CLASS_LOAD);
   add_row(imm_form_word(idu_pkg::OP_STB, 6'd27, 6'd28, 14'h0004), 1'b0, CLASS_STORE);
   add_row(imm_form_word(idu_pkg::OP_STH, 6'd29, 6'd30, 14'h3ffc), 1'b0, CLASS_STORE);
   add_row(imm_form_word(idu_pkg::OP_STW, 6'd31, 6'd0, 14'h0100), 1'b0, CLASS_STORE);
   add_row(wide_form_word(idu_pkg::OP_MBARR, 6'd0, 18'h00055), 1'b0, CLASS_BARR);

   // Opcodes outside the set go to emulation
   add_row(reg_form_word(6'h3f, 6'd1, 6'd2, 6'd3), 1'b0, CLASS_EMU);
   add_row(reg_form_word(6'h00, 6'd4, 6'd5, 6'd6), 1'b0, CLASS_EMU);

   // Flushed rows
   add_row(reg_form_word(idu_pkg::OP_ADD, 6'd7, 6'd8, 6'd9), 1'b1, CLASS_ARITH);
   add_row(imm_form_word(idu_pkg::OP_LDW, 6'd10, 6'd11, 14'h3ffe), 1'b1, CLASS_LOAD);
   add_row(imm_form_word(idu_pkg::OP_STW, 6'd12, 6'd13, 14'h0008), 1'b1, CLASS_STORE);
   add_row(reg_form_word(6'h1c, 6'd1, 6'd1, 6'd1), 1'b1, CLASS_EMU);
endtask

/* tb/tb_idu.sv */
// Decode stage testbench with register preload, table driven decode checks and random back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_idu;

   localparam int DW     = 32;
   localparam int REG_AW = 5;

   localparam logic [2:0] CLASS_LOGIC = 3'd0;
   localparam logic [2:0] CLASS_ARITH = 3'd1;
   localparam logic [2:0] CLASS_LOAD  = 3'd2;
   localparam logic [2:0] CLASS_STORE = 3'd3;
   localparam logic [2:0] CLASS_BARR  = 3'd4;
   localparam logic [2:0] CLASS_EMU   = 3'd5;

   typedef struct packed {
      logic [31:0] op1;
      logic [31:0] op2;
      logic [31:0] op3;
      logic [4:0]  lu;
      logic [4:0]  au;
      logic [2:0]  lsize;
      logic [2:0]  ssize;
      logic        load;
      logic        store;
      logic        barr;
      logic        emu;
      logic        wb_regf;
      logic [4:0]  wb_addr;
      logic        flush;
      logic [7:0]  row;
      logic [2:0]  cls;
   } bundle_t;

   logic clk = 1'b0;
   logic rst_i, insn_valid_i, insn_ready_o, flush_i, ex_valid_o, ex_ready_i, wb_we_i;
   logic [31:0] insn_i;
   logic [REG_AW-1:0] wb_addr_i, wb_reg_addr_o;
   logic [DW-1:0] wb_data_i, operand1_o, operand2_o, operand3_o;
   logic [4:0] lu_opc_o, au_opc_o;
   logic [2:0] load_size_o, store_size_o;
   logic load_o, store_o, barr_o, emu_o, wb_regf_o;

   logic [15:0] lfsr_state = 16'd35;
   logic [31:0] model_regs [32];
   logic [31:0] table_word [$];
   logic        table_flush [$];
   logic [2:0]  table_class [$];
   bundle_t     expected_q [$];
   int check_count = 0;
   int error_count = 0;
   int cycle_count = 0;
   int cycle_limit = 100;
   int next_row = 0;
   int done_count = 0;

   idu_top UUT (.*);

   always #10 clk = ~clk;

   // Run limit scales with the table length
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("The run timed out after %0d cycles before all bundles arrived", cycle_count);
         $display("Result: FAILED");
         $finish;
      end
   end

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic next_random_bit();
      next_random_bit = lfsr_state[0];
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
   endfunction

   function automatic logic [31:0] random_word();
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < 32; k++) begin
         v = {v[30:0], next_random_bit()};
      end
      return v;
   endfunction

   function automatic logic [31:0] reg_form_word(input logic [5:0] opc, input logic [5:0] rd,
                                                 input logic [5:0] rs1, input logic [5:0] rs2);
      // Attribute byte carries junk that decode must ignore
      return {8'ha5, rs2, rs1, rd, opc};
   endfunction

   function automatic logic [31:0] imm_form_word(input logic [5:0] opc, input logic [5:0] rd,
                                                 input logic [5:0] rs1, input logic [13:0] imm);
      return {imm, rs1, rd, opc};
   endfunction

   function automatic logic [31:0] wide_form_word(input logic [5:0] opc, input logic [5:0] rd,
                                                  input logic [17:0] imm);
      return {2'b00, imm, rd, opc};
   endfunction

   task automatic add_row(input logic [31:0] w, input logic fl, input logic [2:0] cls);
      table_word.push_back(w);
      table_flush.push_back(fl);
      table_class.push_back(cls);
   endtask

   // Expected execute bundle from the decode rules and the mirrored registers
   function automatic bundle_t predict(input logic [31:0] w, input logic fl, input int row,
                                       input logic [2:0] cls);
      bundle_t b;
      logic [5:0] opc;
      logic [31:0] simm, uimm, wimm, imm;
      logic reg_form;
      b = '0;
      opc = w[5:0];
      simm = {{18{w[31]}}, w[31:18]};
      uimm = {18'b0, w[31:18]};
      wimm = {14'b0, w[29:12]};
      case (opc)
         idu_pkg::OP_AND, idu_pkg::OP_AND_I: b.lu[idu_pkg::LU_AND] = 1'b1;
         idu_pkg::OP_OR, idu_pkg::OP_OR_I:   b.lu[idu_pkg::LU_OR] = 1'b1;
         idu_pkg::OP_XOR, idu_pkg::OP_XOR_I: b.lu[idu_pkg::LU_XOR] = 1'b1;
         idu_pkg::OP_LSL, idu_pkg::OP_LSL_I: b.lu[idu_pkg::LU_LSL] = 1'b1;
         idu_pkg::OP_LSR, idu_pkg::OP_LSR_I: b.lu[idu_pkg::LU_LSR] = 1'b1;
         idu_pkg::OP_CMP:                    b.au[idu_pkg::AU_CMP] = 1'b1;
         idu_pkg::OP_ADD, idu_pkg::OP_ADD_I: b.au[idu_pkg::AU_ADD] = 1'b1;
         idu_pkg::OP_SUB:                    b.au[idu_pkg::AU_SUB] = 1'b1;
         idu_pkg::OP_MUL:                    b.au[idu_pkg::AU_MUL] = 1'b1;
         idu_pkg::OP_MHI:                    b.au[idu_pkg::AU_MHI] = 1'b1;
         idu_pkg::OP_LDB:                    b.lsize = idu_pkg::SIZE_B;
         idu_pkg::OP_LDH:                    b.lsize = idu_pkg::SIZE_H;
         idu_pkg::OP_LDW:                    b.lsize = idu_pkg::SIZE_W;
         idu_pkg::OP_STB:                    b.ssize = idu_pkg::SIZE_B;
         idu_pkg::OP_STH:                    b.ssize = idu_pkg::SIZE_H;
         idu_pkg::OP_STW:                    b.ssize = idu_pkg::SIZE_W;
         idu_pkg::OP_MBARR:                  b.barr = 1'b1;
         default:                            b.emu = 1'b1;
      endcase
      b.load  = (b.lsize != idu_pkg::SIZE_NONE);
      b.store = (b.ssize != idu_pkg::SIZE_NONE);
      // Barrier has no imm14, so it carries the wide immediate like MHI
      if (opc inside {idu_pkg::OP_AND_I, idu_pkg::OP_XOR_I, idu_pkg::OP_ADD_I} ||
          b.load || b.store) begin
         imm = simm;
      end else if (opc inside {idu_pkg::OP_OR_I, idu_pkg::OP_LSL_I, idu_pkg::OP_LSR_I}) begin
         imm = uimm;
      end else begin
         imm = wimm;
      end
      reg_form = !(opc inside {idu_pkg::OP_AND_I, idu_pkg::OP_OR_I, idu_pkg::OP_XOR_I,
                   idu_pkg::OP_LSL_I, idu_pkg::OP_LSR_I, idu_pkg::OP_ADD_I, idu_pkg::OP_MHI,
                   idu_pkg::OP_MBARR} || b.load || b.store);
      b.wb_regf = !(b.au[idu_pkg::AU_CMP] || b.store || b.barr || b.emu);
      b.op1 = (opc == idu_pkg::OP_MBARR) ? imm : model_regs[w[16:12]];
      b.op2 = reg_form ? model_regs[w[22:18]] : imm;
      b.op3 = b.store ? model_regs[w[10:6]] : '0;
      b.wb_addr = w[10:6];
      b.flush = fl;
      b.row = row[7:0];
      b.cls = cls;
      if (fl) begin
         b.load = 1'b0;
         b.store = 1'b0;
         b.barr = 1'b0;
         b.emu = 1'b0;
         b.wb_regf = 1'b0;
      end
      return b;
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
      check_count++;
      if (got !== want) begin
         error_count++;
         $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   function automatic logic [2:0] observed_class();
      if (lu_opc_o != '0) return CLASS_LOGIC;
      else if (au_opc_o != '0) return CLASS_ARITH;
      else if (load_size_o != '0) return CLASS_LOAD;
      else if (store_size_o != '0) return CLASS_STORE;
      else if (barr_o) return CLASS_BARR;
      else return CLASS_EMU;
   endfunction

   task automatic compare_bundle(input bundle_t e);
      string r;
      r = $sformatf("row %0d ", e.row);
      check_value({r, "operand1_o"}, operand1_o, e.op1);
      check_value({r, "operand2_o"}, operand2_o, e.op2);
      check_value({r, "operand3_o"}, operand3_o, e.op3);
      check_value({r, "lu_opc_o"}, 32'(lu_opc_o), 32'(e.lu));
      check_value({r, "au_opc_o"}, 32'(au_opc_o), 32'(e.au));
      check_value({r, "load_size_o"}, 32'(load_size_o), 32'(e.lsize));
      check_value({r, "store_size_o"}, 32'(store_size_o), 32'(e.ssize));
      check_value({r, "load_o"}, 32'(load_o), 32'(e.load));
      check_value({r, "store_o"}, 32'(store_o), 32'(e.store));
      check_value({r, "barr_o"}, 32'(barr_o), 32'(e.barr));
      check_value({r, "emu_o"}, 32'(emu_o), 32'(e.emu));
      check_value({r, "wb_regf_o"}, 32'(wb_regf_o), 32'(e.wb_regf));
      check_value({r, "wb_reg_addr_o"}, 32'(wb_reg_addr_o), 32'(e.wb_addr));
      if (!e.flush) begin
         check_value({r, "decode class"}, 32'(observed_class()), 32'(e.cls));
      end
   endtask

   initial begin
      logic [31:0] w;
      rst_i = 1'b1;
      insn_valid_i = 1'b0;
      insn_i = '0;
      flush_i = 1'b0;
      ex_ready_i = 1'b0;
      wb_we_i = 1'b0;
      wb_addr_i = '0;
      wb_data_i = '0;
      fill_stimulus_table();
      cycle_limit = 16 * table_word.size() + 100;
      repeat (8) @(negedge clk);
      rst_i = 1'b0;
      #2;
      check_value("ex_valid_o after reset", 32'(ex_valid_o), 32'd0);
      check_value("insn_ready_o after reset", 32'(insn_ready_o), 32'd1);
      check_value("control flags after reset",
                  32'({load_o, store_o, barr_o, emu_o, wb_regf_o}), 32'd0);

      // Preload through the write port, mirrored in the model
      model_regs[0] = '0;
      for (int i = 0; i < 32; i++) begin
         @(negedge clk);
         w = random_word();
         wb_we_i = 1'b1;
         wb_addr_i = 5'(i);
         wb_data_i = w;
         // Register 0 takes a write too and must still read zero
         if (i != 0) begin
            model_regs[i] = w;
         end
      end
      @(negedge clk);
      wb_we_i = 1'b0;

      while (done_count < table_word.size()) begin
         @(negedge clk);
         ex_ready_i = next_random_bit();
         if (next_row < table_word.size()) begin
            insn_valid_i = 1'b1;
            insn_i = table_word[next_row];
            flush_i = table_flush[next_row];
         end else begin
            insn_valid_i = 1'b0;
            insn_i = '0;
            flush_i = 1'b0;
         end
         #2;
         // Held bundle is compared on every stall cycle as well
         if (ex_valid_o) begin
            if (expected_q.size() == 0) begin
               error_count++;
               $display("Error at %0d ns: a bundle was presented with no instruction pending",
                        $time);
            end else begin
               compare_bundle(expected_q[0]);
               if (ex_ready_i) begin
                  void'(expected_q.pop_front());
                  done_count++;
               end
            end
         end
         if (insn_valid_i && insn_ready_o) begin
            expected_q.push_back(predict(insn_i, flush_i, next_row, table_class[next_row]));
            next_row++;
         end
      end

      @(negedge clk);
      ex_ready_i = 1'b0;
      insn_valid_i = 1'b0;
      #2;
      check_value("ex_valid_o after drain", 32'(ex_valid_o), 32'd0);

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   `include "tb_idu_table.svh"

endmodule

`default_nettype wire

/* idu.f */
+incdir+tb
design/idu_pkg.sv
design/idu_regf_rd_if.sv
design/idu_pipebuf.sv
design/idu_regfile.sv
design/idu_decoder.sv
design/idu_top.sv
tb/tb_idu.sv

/* Makefile */
# Verilator simulation of the decode stage

VERILATOR ?= verilator
TOP       ?= tb_idu
FILELIST  ?= idu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: sim clean

# The log is searched for the pass line, so a failing run returns an error
sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) $(VFLAGS)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
